//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP ?= icache_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail is taken from the printed result line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
verilog/icache_pkg.sv
verilog/icache_fill_if.sv
verilog/icache_array.sv
verilog/icache_miss_ctrl.sv
verilog/icache.sv
verilog/icache_wrapper.sv
verif/icache_tb.sv

//--- verif/icache_tb.sv
// instruction cache testbench
module icache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ICACHE_SIZE = 8192;
	localparam int ICACHE_ASSOC = 2;
	localparam int ICACHE_FETCH_WIDTH = 16;
	localparam int LOG_ICACHE_ASSOC = $clog2(ICACHE_ASSOC);
	localparam int ICACHE_NUM_SETS = ICACHE_SIZE / ICACHE_ASSOC / icache_pkg::L1_BLOCK_SIZE;
	localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_NUM_SETS);
	localparam int ICACHE_TAG_WIDTH = icache_pkg::L1_BLOCK_ADDR_WIDTH - ICACHE_INDEX_WIDTH;
	localparam int FETCH_BITS = ICACHE_FETCH_WIDTH * 8;
	localparam int NUM_OFFSETS = icache_pkg::L1_BLOCK_SIZE / ICACHE_FETCH_WIDTH;
	localparam int OFFSET_WIDTH = $clog2(NUM_OFFSETS);

	localparam int CLK_PERIOD = 100;
	localparam int SEED = 49885;
	// input register, array read, output register, then the next falling edge
	localparam int RESP_LATENCY = 4;
	localparam int NUM_RESET_READS = 8;
	localparam int NUM_RANDOM_FILLS = 6;
	localparam int NUM_FILLS = 6 + NUM_RANDOM_FILLS;
	// each fill is a read, a miss and two reads of the result
	localparam int NUM_OPS = NUM_RESET_READS + 4 * NUM_FILLS + 8;
	localparam int WATCHDOG_CYCLES = NUM_OPS * 40;

	localparam int FILL_PLAIN = 0;
	localparam int FILL_SNOOPED = 1;
	localparam int FILL_DOUBLE_MISS = 2;

	typedef logic [ICACHE_ASSOC-1:0] way_vec_t;
	typedef logic [ICACHE_TAG_WIDTH-1:0] tag_t;
	typedef logic [ICACHE_INDEX_WIDTH-1:0] index_t;
	typedef logic [ICACHE_ASSOC-1:0][ICACHE_TAG_WIDTH-1:0] tag_vec_t;
	typedef icache_pkg::fetch_data_t [ICACHE_ASSOC-1:0] instr_vec_t;

	logic CLK = 1'b0;
	logic nRST;
	logic next_core_req_valid;
	logic [OFFSET_WIDTH-1:0] next_core_req_block_offset;
	index_t next_core_req_index;
	way_vec_t last_core_resp_valid_by_way;
	tag_vec_t last_core_resp_tag_by_way;
	instr_vec_t last_core_resp_instr_16B_by_way;
	logic next_core_resp_hit_valid;
	logic [LOG_ICACHE_ASSOC-1:0] next_core_resp_hit_way;
	logic next_core_resp_miss_valid;
	tag_t next_core_resp_miss_tag;
	logic last_l2_req_valid;
	icache_pkg::block_addr_t last_l2_req_PA29;
	logic next_l2_req_ready;
	logic next_l2_resp_valid;
	icache_pkg::block_addr_t next_l2_resp_PA29;
	icache_pkg::block_data_t next_l2_resp_data256;
	logic next_l2_snoop_inv_valid;
	icache_pkg::block_addr_t next_l2_snoop_inv_PA29;

	// reference cache state
	way_vec_t ref_valid [ICACHE_NUM_SETS];
	tag_t ref_tag [ICACHE_NUM_SETS][ICACHE_ASSOC];
	icache_pkg::block_data_t ref_data [ICACHE_NUM_SETS][ICACHE_ASSOC];
	int ref_mru [ICACHE_NUM_SETS];

	// scoreboard
	int unsigned cycle = 0;
	int unsigned exp_due [$];
	way_vec_t exp_valid [$];
	tag_vec_t exp_tag [$];
	instr_vec_t exp_instr [$];
	icache_pkg::block_addr_t exp_l2_addr [$];
	int exp_l2_req_count = 0;
	int l2_req_count = 0;
	int l2_resp_count = 0;
	logic req_seen = 1'b0;
	icache_pkg::block_addr_t req_addr;

	icache_wrapper #(
		.ICACHE_SIZE(ICACHE_SIZE),
		.ICACHE_ASSOC(ICACHE_ASSOC),
		.ICACHE_FETCH_WIDTH(ICACHE_FETCH_WIDTH)
	) u_dut (.*);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	always @(posedge CLK) begin
		cycle <= cycle + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	// eight words, each the block address and the word number
	function automatic icache_pkg::block_data_t block_pattern(input icache_pkg::block_addr_t addr);
		icache_pkg::block_data_t d;
		for (int w = 0; w < icache_pkg::L1_BLOCK_SIZE_BITS / 32; w++) begin
			d[w * 32 +: 32] = {addr, 3'(w)} ^ 32'h9e37_79b9;
		end
		return d;
	endfunction

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------
	function automatic void predict_read(input index_t idx, input int off,
		output way_vec_t v, output tag_vec_t t, output instr_vec_t d);
		v = ref_valid[idx];
		for (int w = 0; w < ICACHE_ASSOC; w++) begin
			t[w] = ref_tag[idx][w];
			d[w] = ref_data[idx][w][off * FETCH_BITS +: FETCH_BITS];
		end
	endfunction

	// lowest invalid way first, else the way after MRU
	function automatic void apply_install(input index_t idx, input tag_t tag);
		int victim;
		victim = (ref_mru[idx] + 1) % ICACHE_ASSOC;
		for (int w = ICACHE_ASSOC - 1; w >= 0; w--) begin
			if (!ref_valid[idx][w]) begin
				victim = w;
			end
		end
		ref_valid[idx][victim] = 1'b1;
		ref_tag[idx][victim] = tag;
		ref_data[idx][victim] = block_pattern({tag, idx});
		ref_mru[idx] = victim;
	endfunction

	function automatic void apply_snoop(input icache_pkg::block_addr_t addr);
		index_t idx;
		tag_t tag;
		idx = addr[ICACHE_INDEX_WIDTH-1:0];
		tag = addr[ICACHE_INDEX_WIDTH +: ICACHE_TAG_WIDTH];
		for (int w = 0; w < ICACHE_ASSOC; w++) begin
			if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
				ref_valid[idx][w] = 1'b0;
			end
		end
	endfunction

	// ------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------
	task automatic check_resp(input way_vec_t exp_v, input tag_vec_t exp_t,
		input instr_vec_t exp_d);
		if (last_core_resp_valid_by_way !== exp_v) begin
			abort_run($sformatf("FAIL last_core_resp_valid_by_way expected 0x%0h got 0x%0h",
				exp_v, last_core_resp_valid_by_way));
		end
		// tag and data only mean something for a valid way
		for (int w = 0; w < ICACHE_ASSOC; w++) begin
			if (exp_v[w] && last_core_resp_tag_by_way[w] !== exp_t[w]) begin
				abort_run($sformatf("FAIL last_core_resp_tag_by_way[%0d] expected 0x%0h got 0x%0h",
					w, exp_t[w], last_core_resp_tag_by_way[w]));
			end
			if (exp_v[w] && last_core_resp_instr_16B_by_way[w] !== exp_d[w]) begin
				abort_run($sformatf(
					"FAIL last_core_resp_instr_16B_by_way[%0d] expected 0x%0h got 0x%0h",
					w, exp_d[w], last_core_resp_instr_16B_by_way[w]));
			end
		end
	endtask

	task automatic check_l2_req(input icache_pkg::block_addr_t exp_addr);
		if (last_l2_req_PA29 !== exp_addr) begin
			abort_run($sformatf("FAIL last_l2_req_PA29 expected 0x%0h got 0x%0h",
				exp_addr, last_l2_req_PA29));
		end
	endtask

	// one scoreboard entry per read in flight
	always @(negedge CLK) begin
		if (exp_due.size() > 0 && exp_due[0] == cycle) begin
			check_resp(exp_valid[0], exp_tag[0], exp_instr[0]);
			void'(exp_due.pop_front());
			void'(exp_valid.pop_front());
			void'(exp_tag.pop_front());
			void'(exp_instr.pop_front());
		end
	end

	// L2 request monitor, address must hold for the whole request
	always @(negedge CLK) begin
		if (nRST && last_l2_req_valid) begin
			if (!req_seen && exp_l2_addr.size() == 0) begin
				abort_run("an L2 request was raised with no accepted miss behind it");
			end else if (!req_seen) begin
				req_addr = exp_l2_addr.pop_front();
				l2_req_count++;
				req_seen = 1'b1;
			end
			check_l2_req(req_addr);
		end else begin
			req_seen = 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// L2 responder
	// ------------------------------------------------------------------
	initial begin : l2_responder
		icache_pkg::block_addr_t addr;
		int unsigned wait_cycles;
		next_l2_req_ready = 1'b0;
		next_l2_resp_valid = 1'b0;
		next_l2_resp_PA29 = '0;
		next_l2_resp_data256 = '0;
		forever begin
			@(negedge CLK);
			if (nRST && last_l2_req_valid) begin
				addr = last_l2_req_PA29;
				wait_cycles = $urandom_range(6, 0);
				repeat (wait_cycles) @(negedge CLK);
				next_l2_req_ready = 1'b1;
				while (last_l2_req_valid) begin
					@(negedge CLK);
				end
				next_l2_req_ready = 1'b0;
				wait_cycles = $urandom_range(6, 0);
				repeat (wait_cycles) @(negedge CLK);
				next_l2_resp_valid = 1'b1;
				next_l2_resp_PA29 = addr;
				next_l2_resp_data256 = block_pattern(addr);
				@(negedge CLK);
				next_l2_resp_valid = 1'b0;
				l2_resp_count++;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("timeout, the test sequence did not finish in the allowed cycles");
	end

	// ------------------------------------------------------------------
	// core side stimulus
	// ------------------------------------------------------------------
	task automatic issue_read(input index_t idx, input int off);
		way_vec_t v;
		tag_vec_t t;
		instr_vec_t d;
		predict_read(idx, off, v, t, d);
		exp_due.push_back(cycle + RESP_LATENCY);
		exp_valid.push_back(v);
		exp_tag.push_back(t);
		exp_instr.push_back(d);
		next_core_req_valid = 1'b1;
		next_core_req_index = idx;
		next_core_req_block_offset = OFFSET_WIDTH'(off);
		@(negedge CLK);
		next_core_req_valid = 1'b0;
	endtask

	task automatic wait_reads();
		while (exp_due.size() > 0) begin
			@(negedge CLK);
		end
	endtask

	task automatic read_both_halves(input index_t idx);
		issue_read(idx, 0);
		issue_read(idx, 1);
		wait_reads();
	endtask

	task automatic send_miss(input tag_t tag);
		next_core_resp_miss_valid = 1'b1;
		next_core_resp_miss_tag = tag;
		@(negedge CLK);
		next_core_resp_miss_valid = 1'b0;
	endtask

	// applies to the set of the last read
	task automatic send_hit(input index_t idx, input int way);
		ref_mru[idx] = way;
		next_core_resp_hit_valid = 1'b1;
		next_core_resp_hit_way = LOG_ICACHE_ASSOC'(way);
		@(negedge CLK);
		next_core_resp_hit_valid = 1'b0;
	endtask

	task automatic send_snoop(input icache_pkg::block_addr_t addr);
		next_l2_snoop_inv_valid = 1'b1;
		next_l2_snoop_inv_PA29 = addr;
		@(negedge CLK);
		next_l2_snoop_inv_valid = 1'b0;
		repeat (2) @(negedge CLK);
		apply_snoop(addr);
	endtask

	task automatic fill_block(input index_t idx, input tag_t tag, input int mode);
		int resp_before;
		icache_pkg::block_addr_t addr;
		addr = {tag, idx};
		issue_read(idx, 0);
		wait_reads();
		resp_before = l2_resp_count;
		exp_l2_addr.push_back(addr);
		exp_l2_req_count++;
		send_miss(tag);
		if (mode != FILL_PLAIN) begin
			while (!last_l2_req_valid) begin
				@(negedge CLK);
			end
			if (mode == FILL_SNOOPED) begin
				send_snoop(addr);
			end else begin
				send_miss(tag ^ tag_t'(1));
			end
		end
		while (l2_resp_count == resp_before) begin
			@(negedge CLK);
		end
		// install lands two edges after the response
		repeat (3) @(negedge CLK);
		if (mode != FILL_SNOOPED) begin
			apply_install(idx, tag);
		end
	endtask

	initial begin : stimulus
		index_t set_a;
		index_t set_b;
		index_t set_c;
		tag_t tag_a;
		tag_t tag_b;
		tag_t tag_c;
		void'($urandom(SEED));
		nRST = 1'b0;
		next_core_req_valid = 1'b0;
		next_core_req_block_offset = '0;
		next_core_req_index = '0;
		next_core_resp_hit_valid = 1'b0;
		next_core_resp_hit_way = '0;
		next_core_resp_miss_valid = 1'b0;
		next_core_resp_miss_tag = '0;
		next_l2_snoop_inv_valid = 1'b0;
		next_l2_snoop_inv_PA29 = '0;
		for (int s = 0; s < ICACHE_NUM_SETS; s++) begin
			ref_valid[s] = '0;
			ref_mru[s] = 0;
		end
		repeat (4) @(negedge CLK);
		nRST = 1'b1;
		@(negedge CLK);

		// empty cache, several reads in flight at once
		for (int i = 0; i < NUM_RESET_READS; i++) begin
			issue_read(index_t'($urandom), int'($urandom_range(NUM_OFFSETS - 1, 0)));
		end
		wait_reads();
		if (last_l2_req_valid) begin
			abort_run("last_l2_req_valid went high after reset without any miss");
		end

		set_a = index_t'($urandom);
		set_b = set_a + index_t'(1);
		set_c = set_a + index_t'(2);
		tag_a = tag_t'($urandom);
		tag_b = tag_t'($urandom);
		tag_c = tag_t'($urandom);

		// two fills take way 0 then way 1
		fill_block(set_a, tag_a, FILL_PLAIN);
		read_both_halves(set_a);
		fill_block(set_a, tag_a ^ tag_t'(1), FILL_PLAIN);
		read_both_halves(set_a);

		// hit on way 0 makes way 1 the victim
		issue_read(set_a, 0);
		wait_reads();
		send_hit(set_a, 0);
		fill_block(set_a, tag_a ^ tag_t'(2), FILL_PLAIN);
		read_both_halves(set_a);

		// snoop drops way 0 only
		send_snoop({tag_a, set_a});
		read_both_halves(set_a);

		// snoop on the block being fetched cancels its install
		fill_block(set_b, tag_b, FILL_PLAIN);
		fill_block(set_b, tag_b ^ tag_t'(1), FILL_SNOOPED);
		read_both_halves(set_b);

		// second miss while one is pending is dropped
		fill_block(set_c, tag_c, FILL_DOUBLE_MISS);
		repeat (20) @(negedge CLK);
		read_both_halves(set_c);

		for (int i = 0; i < NUM_RANDOM_FILLS; i++) begin
			fill_block(set_a + index_t'($urandom_range(3, 0)), tag_t'($urandom), FILL_PLAIN);
			read_both_halves(set_a + index_t'(i % 4));
		end

		repeat (10) @(negedge CLK);
		if (l2_req_count != exp_l2_req_count) begin
			abort_run($sformatf("%0d L2 requests were seen where %0d were expected",
				l2_req_count, exp_l2_req_count));
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

//--- verilog/icache.sv
// instruction cache core
module icache #(
	parameter int ICACHE_SIZE = 8192,
	parameter int ICACHE_ASSOC = 2,
	parameter int ICACHE_FETCH_WIDTH = 16,
	localparam int LOG_ICACHE_ASSOC = $clog2(ICACHE_ASSOC),
	localparam int ICACHE_NUM_SETS = ICACHE_SIZE / ICACHE_ASSOC / icache_pkg::L1_BLOCK_SIZE,
	localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_NUM_SETS),
	localparam int ICACHE_TAG_WIDTH = icache_pkg::L1_BLOCK_ADDR_WIDTH - ICACHE_INDEX_WIDTH,
	localparam int ICACHE_FETCH_BLOCK_OFFSET_WIDTH =
		$clog2(icache_pkg::L1_BLOCK_SIZE / ICACHE_FETCH_WIDTH)
) (
	input logic CLK,
	input logic nRST,

	input logic core_req_valid,
	input logic [ICACHE_FETCH_BLOCK_OFFSET_WIDTH-1:0] core_req_block_offset,
	input logic [ICACHE_INDEX_WIDTH-1:0] core_req_index,

	output logic [ICACHE_ASSOC-1:0] core_resp_valid_by_way,
	output logic [ICACHE_ASSOC-1:0][ICACHE_TAG_WIDTH-1:0] core_resp_tag_by_way,
	output icache_pkg::fetch_data_t [ICACHE_ASSOC-1:0] core_resp_instr_16B_by_way,

	input logic core_resp_hit_valid,
	input logic [LOG_ICACHE_ASSOC-1:0] core_resp_hit_way,
	input logic core_resp_miss_valid,
	input logic [ICACHE_TAG_WIDTH-1:0] core_resp_miss_tag,

	output logic l2_req_valid,
	output icache_pkg::block_addr_t l2_req_PA29,
	input logic l2_req_ready,

	input logic l2_resp_valid,
	input icache_pkg::block_addr_t l2_resp_PA29,
	input icache_pkg::block_data_t l2_resp_data256,

	input logic l2_snoop_inv_valid,
	input icache_pkg::block_addr_t l2_snoop_inv_PA29
);

	// request stage
	logic req_valid_q;
	logic [ICACHE_INDEX_WIDTH-1:0] req_index_q;
	logic [ICACHE_FETCH_BLOCK_OFFSET_WIDTH-1:0] req_offset_q;
	// set of the response most recently handed to the core
	logic [ICACHE_INDEX_WIDTH-1:0] resp_index_q;

	// feedback stage
	logic fb_hit_valid_q;
	logic [LOG_ICACHE_ASSOC-1:0] fb_hit_way_q;
	logic fb_miss_valid_q;
	logic [ICACHE_TAG_WIDTH-1:0] fb_miss_tag_q;

	logic [ICACHE_NUM_SETS-1:0][ICACHE_ASSOC-1:0] valid_by_set_way;

	icache_fill_if #(
		.ICACHE_ASSOC(ICACHE_ASSOC),
		.ICACHE_INDEX_WIDTH(ICACHE_INDEX_WIDTH),
		.ICACHE_TAG_WIDTH(ICACHE_TAG_WIDTH)
	) fill_bus ();

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			req_valid_q <= 1'b0;
			fb_hit_valid_q <= 1'b0;
			fb_miss_valid_q <= 1'b0;
		end else begin
			req_valid_q <= core_req_valid;
			fb_hit_valid_q <= core_resp_hit_valid;
			fb_miss_valid_q <= core_resp_miss_valid;
		end
	end

	always_ff @(posedge CLK) begin
		req_index_q <= core_req_index;
		req_offset_q <= core_req_block_offset;
		fb_hit_way_q <= core_resp_hit_way;
		fb_miss_tag_q <= core_resp_miss_tag;
		if (req_valid_q) begin
			resp_index_q <= req_index_q;
		end
	end

	// ------------------------------------------------------------------
	// arrays and miss handling
	// ------------------------------------------------------------------
	icache_array #(
		.ICACHE_SIZE(ICACHE_SIZE),
		.ICACHE_ASSOC(ICACHE_ASSOC),
		.ICACHE_FETCH_WIDTH(ICACHE_FETCH_WIDTH)
	) u_array (
		.CLK(CLK),
		.nRST(nRST),
		.rd_valid(req_valid_q),
		.rd_index(req_index_q),
		.rd_offset(req_offset_q),
		.resp_valid_by_way(core_resp_valid_by_way),
		.resp_tag_by_way(core_resp_tag_by_way),
		.resp_instr_by_way(core_resp_instr_16B_by_way),
		.fill(fill_bus.array),
		.snoop_valid(l2_snoop_inv_valid),
		.snoop_addr(l2_snoop_inv_PA29),
		.valid_by_set_way(valid_by_set_way)
	);

	icache_miss_ctrl #(
		.ICACHE_SIZE(ICACHE_SIZE),
		.ICACHE_ASSOC(ICACHE_ASSOC)
	) u_miss_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.miss_valid(fb_miss_valid_q),
		.miss_tag(fb_miss_tag_q),
		.miss_index(resp_index_q),
		.hit_valid(fb_hit_valid_q),
		.hit_way(fb_hit_way_q),
		.valid_by_set_way(valid_by_set_way),
		.l2_req_valid(l2_req_valid),
		.l2_req_PA29(l2_req_PA29),
		.l2_req_ready(l2_req_ready),
		.l2_resp_valid(l2_resp_valid),
		.l2_resp_PA29(l2_resp_PA29),
		.l2_resp_data256(l2_resp_data256),
		.snoop_valid(l2_snoop_inv_valid),
		.snoop_addr(l2_snoop_inv_PA29),
		.fill(fill_bus.ctrl)
	);

	// core reports either a hit or a miss for a response, never both
	a_fb_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
		!(core_resp_hit_valid && core_resp_miss_valid));

endmodule

//--- verilog/icache_array.sv
// instruction cache tag and data arrays
module icache_array #(
	parameter int ICACHE_SIZE = 8192,
	parameter int ICACHE_ASSOC = 2,
	parameter int ICACHE_FETCH_WIDTH = 16,
	localparam int LOG_ICACHE_ASSOC = $clog2(ICACHE_ASSOC),
	localparam int ICACHE_NUM_SETS = ICACHE_SIZE / ICACHE_ASSOC / icache_pkg::L1_BLOCK_SIZE,
	localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_NUM_SETS),
	localparam int ICACHE_TAG_WIDTH = icache_pkg::L1_BLOCK_ADDR_WIDTH - ICACHE_INDEX_WIDTH,
	localparam int ICACHE_FETCH_BLOCK_OFFSET_WIDTH =
		$clog2(icache_pkg::L1_BLOCK_SIZE / ICACHE_FETCH_WIDTH)
) (
	input logic CLK,
	input logic nRST,

	// fetch read
	input logic rd_valid,
	input logic [ICACHE_INDEX_WIDTH-1:0] rd_index,
	input logic [ICACHE_FETCH_BLOCK_OFFSET_WIDTH-1:0] rd_offset,
	output logic [ICACHE_ASSOC-1:0] resp_valid_by_way,
	output logic [ICACHE_ASSOC-1:0][ICACHE_TAG_WIDTH-1:0] resp_tag_by_way,
	output icache_pkg::fetch_data_t [ICACHE_ASSOC-1:0] resp_instr_by_way,

	// install from miss controller
	icache_fill_if.array fill,

	// snoop invalidation
	input logic snoop_valid,
	input icache_pkg::block_addr_t snoop_addr,

	// for victim choice
	output logic [ICACHE_NUM_SETS-1:0][ICACHE_ASSOC-1:0] valid_by_set_way
);

	localparam int FETCH_BITS = ICACHE_FETCH_WIDTH * 8;

	logic [ICACHE_TAG_WIDTH-1:0] tag_mem [ICACHE_ASSOC][ICACHE_NUM_SETS];
	icache_pkg::block_data_t data_mem [ICACHE_ASSOC][ICACHE_NUM_SETS];
	logic [ICACHE_NUM_SETS-1:0][ICACHE_ASSOC-1:0] valid_q;

	// snoop stage, compare happens one cycle after arrival
	logic snoop_valid_q;
	icache_pkg::block_addr_t snoop_addr_q;
	logic [ICACHE_INDEX_WIDTH-1:0] snoop_index;
	logic [ICACHE_TAG_WIDTH-1:0] snoop_tag;
	logic [ICACHE_ASSOC-1:0] snoop_hit;

	assign valid_by_set_way = valid_q;
	assign snoop_index = snoop_addr_q[ICACHE_INDEX_WIDTH-1:0];
	assign snoop_tag = snoop_addr_q[ICACHE_INDEX_WIDTH +: ICACHE_TAG_WIDTH];

	always_comb begin
		for (int w = 0; w < ICACHE_ASSOC; w++) begin
			snoop_hit[w] = snoop_valid_q && valid_q[snoop_index][w]
				&& (tag_mem[w][snoop_index] == snoop_tag);
		end
	end

	// ------------------------------------------------------------------
	// storage and read path
	// ------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (fill.valid) begin
			tag_mem[fill.way][fill.index] <= fill.tag;
			data_mem[fill.way][fill.index] <= fill.data;
		end
		// pick the requested half of every way
		if (rd_valid) begin
			for (int w = 0; w < ICACHE_ASSOC; w++) begin
				resp_tag_by_way[w] <= tag_mem[w][rd_index];
				resp_instr_by_way[w] <= data_mem[w][rd_index][rd_offset * FETCH_BITS +: FETCH_BITS];
			end
		end
		if (snoop_valid) begin
			snoop_addr_q <= snoop_addr;
		end
	end

	// ------------------------------------------------------------------
	// valid bits
	// ------------------------------------------------------------------
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			resp_valid_by_way <= '0;
			snoop_valid_q <= 1'b0;
		end else begin
			resp_valid_by_way <= rd_valid ? valid_q[rd_index] : '0;
			snoop_valid_q <= snoop_valid;
			if (fill.valid) begin
				valid_q[fill.index][fill.way] <= 1'b1;
			end
			// later assignment, so snoop beats a same-entry install
			for (int w = 0; w < ICACHE_ASSOC; w++) begin
				if (snoop_hit[w]) begin
					valid_q[snoop_index][w] <= 1'b0;
				end
			end
		end
	end

	a_fill_way_range: assert property (@(posedge CLK) disable iff (!nRST)
		fill.valid |-> (int'(fill.way) < ICACHE_ASSOC));

endmodule

//--- verilog/icache_fill_if.sv
// block install channel
interface icache_fill_if #(
	parameter int ICACHE_ASSOC = 2,
	parameter int ICACHE_INDEX_WIDTH = 7,
	parameter int ICACHE_TAG_WIDTH = 22
);

	localparam int LOG_ICACHE_ASSOC = $clog2(ICACHE_ASSOC);

	// single-cycle install pulse
	logic valid;
	logic [LOG_ICACHE_ASSOC-1:0] way;
	logic [ICACHE_INDEX_WIDTH-1:0] index;
	logic [ICACHE_TAG_WIDTH-1:0] tag;
	icache_pkg::block_data_t data;

	// miss controller side
	modport ctrl (output valid, way, index, tag, data);

	// storage side
	modport array (input valid, way, index, tag, data);

endinterface

//--- verilog/icache_miss_ctrl.sv
// instruction cache miss controller
module icache_miss_ctrl #(
	parameter int ICACHE_SIZE = 8192,
	parameter int ICACHE_ASSOC = 2,
	localparam int LOG_ICACHE_ASSOC = $clog2(ICACHE_ASSOC),
	localparam int ICACHE_NUM_SETS = ICACHE_SIZE / ICACHE_ASSOC / icache_pkg::L1_BLOCK_SIZE,
	localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_NUM_SETS),
	localparam int ICACHE_TAG_WIDTH = icache_pkg::L1_BLOCK_ADDR_WIDTH - ICACHE_INDEX_WIDTH
) (
	input logic CLK,
	input logic nRST,

	// core feedback
	input logic miss_valid,
	input logic [ICACHE_TAG_WIDTH-1:0] miss_tag,
	input logic [ICACHE_INDEX_WIDTH-1:0] miss_index,
	input logic hit_valid,
	input logic [LOG_ICACHE_ASSOC-1:0] hit_way,

	input logic [ICACHE_NUM_SETS-1:0][ICACHE_ASSOC-1:0] valid_by_set_way,

	// L2 request
	output logic l2_req_valid,
	output icache_pkg::block_addr_t l2_req_PA29,
	input logic l2_req_ready,

	// L2 response
	input logic l2_resp_valid,
	input icache_pkg::block_addr_t l2_resp_PA29,
	input icache_pkg::block_data_t l2_resp_data256,

	input logic snoop_valid,
	input icache_pkg::block_addr_t snoop_addr,

	icache_fill_if.ctrl fill
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_RESP
	} miss_state_t;

	miss_state_t state_q;
	icache_pkg::block_addr_t pend_addr_q;
	logic no_install_q;
	logic [ICACHE_NUM_SETS-1:0][LOG_ICACHE_ASSOC-1:0] mru_q;

	logic [ICACHE_INDEX_WIDTH-1:0] pend_index;
	logic [ICACHE_TAG_WIDTH-1:0] pend_tag;
	logic [ICACHE_ASSOC-1:0] pend_set_valid;
	logic [LOG_ICACHE_ASSOC-1:0] victim_way;
	logic snoop_match;
	logic resp_take;

	assign pend_index = pend_addr_q[ICACHE_INDEX_WIDTH-1:0];
	assign pend_tag = pend_addr_q[ICACHE_INDEX_WIDTH +: ICACHE_TAG_WIDTH];
	assign pend_set_valid = valid_by_set_way[pend_index];

	assign l2_req_valid = (state_q == REQ);
	assign l2_req_PA29 = pend_addr_q;

	assign snoop_match = snoop_valid && (state_q != IDLE) && (snoop_addr == pend_addr_q);
	assign resp_take = (state_q == WAIT_RESP) && l2_resp_valid && (l2_resp_PA29 == pend_addr_q);

	// ------------------------------------------------------------------
	// victim: lowest invalid way, else the one after MRU
	// ------------------------------------------------------------------
	always_comb begin
		if (mru_q[pend_index] == LOG_ICACHE_ASSOC'(ICACHE_ASSOC - 1)) begin
			victim_way = '0;
		end else begin
			victim_way = mru_q[pend_index] + 1'b1;
		end
		for (int w = ICACHE_ASSOC - 1; w >= 0; w--) begin
			if (!pend_set_valid[w]) begin
				victim_way = LOG_ICACHE_ASSOC'(w);
			end
		end
	end

	// ------------------------------------------------------------------
	// state, MRU and no-install flag
	// ------------------------------------------------------------------
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state_q <= IDLE;
			no_install_q <= 1'b0;
			mru_q <= '0;
			fill.valid <= 1'b0;
		end else begin
			fill.valid <= 1'b0;
			if (hit_valid) begin
				mru_q[miss_index] <= hit_way;
			end
			case (state_q)
				IDLE: begin
					// misses while busy are dropped, core retries
					if (miss_valid) begin
						state_q <= REQ;
						no_install_q <= 1'b0;
					end
				end
				REQ: begin
					if (l2_req_ready) begin
						state_q <= WAIT_RESP;
					end
				end
				WAIT_RESP: begin
					if (resp_take) begin
						state_q <= IDLE;
						if (!no_install_q && !snoop_match) begin
							fill.valid <= 1'b1;
							mru_q[pend_index] <= victim_way;
						end
					end
				end
				default: state_q <= IDLE;
			endcase
			if (snoop_match) begin
				no_install_q <= 1'b1;
			end
		end
	end

	// pending address and install payload
	always_ff @(posedge CLK) begin
		if (state_q == IDLE && miss_valid) begin
			pend_addr_q <= {miss_tag, miss_index};
		end
		if (resp_take) begin
			fill.way <= victim_way;
			fill.index <= pend_index;
			fill.tag <= pend_tag;
			fill.data <= l2_resp_data256;
		end
	end

	a_l2_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
		(l2_req_valid && !l2_req_ready) |=> (l2_req_valid && $stable(l2_req_PA29)));

endmodule

//--- verilog/icache_pkg.sv
// instruction cache shared types
package icache_pkg;

	// ------------------------------------------------------------------
	// physical address
	// ------------------------------------------------------------------
	parameter int PA_WIDTH = 34;

	// ------------------------------------------------------------------
	// L1 block geometry
	// ------------------------------------------------------------------
	parameter int L1_BLOCK_SIZE = 32;
	parameter int L1_BLOCK_SIZE_BITS = L1_BLOCK_SIZE * 8;

	// block address is the PA without the byte offset
	parameter int L1_BLOCK_ADDR_WIDTH = PA_WIDTH - $clog2(L1_BLOCK_SIZE);

	// ------------------------------------------------------------------
	// fetch granule returned to the core
	// ------------------------------------------------------------------
	parameter int L1_FETCH_SIZE = 16;
	parameter int L1_FETCH_SIZE_BITS = L1_FETCH_SIZE * 8;

	// tag in the upper bits, set index in the lower bits
	typedef logic [L1_BLOCK_ADDR_WIDTH-1:0] block_addr_t;

	// full block as delivered by L2
	typedef logic [L1_BLOCK_SIZE_BITS-1:0] block_data_t;

	// one 16-byte half of a block
	typedef logic [L1_FETCH_SIZE_BITS-1:0] fetch_data_t;

endpackage

//--- verilog/icache_wrapper.sv
// instruction cache boundary registers
module icache_wrapper #(
	parameter int ICACHE_SIZE = 8192,
	parameter int ICACHE_ASSOC = 2,
	parameter int ICACHE_FETCH_WIDTH = 16,
	localparam int LOG_ICACHE_ASSOC = $clog2(ICACHE_ASSOC),
	localparam int ICACHE_NUM_SETS = ICACHE_SIZE / ICACHE_ASSOC / icache_pkg::L1_BLOCK_SIZE,
	localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_NUM_SETS),
	localparam int ICACHE_TAG_WIDTH = icache_pkg::L1_BLOCK_ADDR_WIDTH - ICACHE_INDEX_WIDTH,
	localparam int ICACHE_FETCH_BLOCK_OFFSET_WIDTH =
		$clog2(icache_pkg::L1_BLOCK_SIZE / ICACHE_FETCH_WIDTH)
) (
	input logic CLK,
	input logic nRST,

	// fetch request
	input logic next_core_req_valid,
	input logic [ICACHE_FETCH_BLOCK_OFFSET_WIDTH-1:0] next_core_req_block_offset,
	input logic [ICACHE_INDEX_WIDTH-1:0] next_core_req_index,

	// fetch response
	output logic [ICACHE_ASSOC-1:0] last_core_resp_valid_by_way,
	output logic [ICACHE_ASSOC-1:0][ICACHE_TAG_WIDTH-1:0] last_core_resp_tag_by_way,
	output icache_pkg::fetch_data_t [ICACHE_ASSOC-1:0] last_core_resp_instr_16B_by_way,

	// hit / miss feedback
	input logic next_core_resp_hit_valid,
	input logic [LOG_ICACHE_ASSOC-1:0] next_core_resp_hit_way,
	input logic next_core_resp_miss_valid,
	input logic [ICACHE_TAG_WIDTH-1:0] next_core_resp_miss_tag,

	// L2 block request
	output logic last_l2_req_valid,
	output icache_pkg::block_addr_t last_l2_req_PA29,
	input logic next_l2_req_ready,

	// L2 block response
	input logic next_l2_resp_valid,
	input icache_pkg::block_addr_t next_l2_resp_PA29,
	input icache_pkg::block_data_t next_l2_resp_data256,

	// L2 snoop
	input logic next_l2_snoop_inv_valid,
	input icache_pkg::block_addr_t next_l2_snoop_inv_PA29
);

	logic core_req_valid;
	logic [ICACHE_FETCH_BLOCK_OFFSET_WIDTH-1:0] core_req_block_offset;
	logic [ICACHE_INDEX_WIDTH-1:0] core_req_index;
	logic [ICACHE_ASSOC-1:0] core_resp_valid_by_way;
	logic [ICACHE_ASSOC-1:0][ICACHE_TAG_WIDTH-1:0] core_resp_tag_by_way;
	icache_pkg::fetch_data_t [ICACHE_ASSOC-1:0] core_resp_instr_16B_by_way;
	logic core_resp_hit_valid;
	logic [LOG_ICACHE_ASSOC-1:0] core_resp_hit_way;
	logic core_resp_miss_valid;
	logic [ICACHE_TAG_WIDTH-1:0] core_resp_miss_tag;
	logic l2_req_valid;
	icache_pkg::block_addr_t l2_req_PA29;
	logic l2_req_ready;
	logic l2_resp_valid;
	icache_pkg::block_addr_t l2_resp_PA29;
	icache_pkg::block_data_t l2_resp_data256;
	logic l2_snoop_inv_valid;
	icache_pkg::block_addr_t l2_snoop_inv_PA29;

	icache #(
		.ICACHE_SIZE(ICACHE_SIZE),
		.ICACHE_ASSOC(ICACHE_ASSOC),
		.ICACHE_FETCH_WIDTH(ICACHE_FETCH_WIDTH)
	) u_icache (.*);

	// ------------------------------------------------------------------
	// one register stage on every port
	// ------------------------------------------------------------------
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			core_req_valid <= 1'b0;
			core_req_block_offset <= '0;
			core_req_index <= '0;
			last_core_resp_valid_by_way <= '0;
			last_core_resp_tag_by_way <= '0;
			last_core_resp_instr_16B_by_way <= '0;
			core_resp_hit_valid <= 1'b0;
			core_resp_hit_way <= '0;
			core_resp_miss_valid <= 1'b0;
			core_resp_miss_tag <= '0;
			last_l2_req_valid <= 1'b0;
			last_l2_req_PA29 <= '0;
			l2_req_ready <= 1'b0;
			l2_resp_valid <= 1'b0;
			l2_resp_PA29 <= '0;
			l2_resp_data256 <= '0;
			l2_snoop_inv_valid <= 1'b0;
			l2_snoop_inv_PA29 <= '0;
		end else begin
			// inbound
			core_req_valid <= next_core_req_valid;
			core_req_block_offset <= next_core_req_block_offset;
			core_req_index <= next_core_req_index;
			core_resp_hit_valid <= next_core_resp_hit_valid;
			core_resp_hit_way <= next_core_resp_hit_way;
			core_resp_miss_valid <= next_core_resp_miss_valid;
			core_resp_miss_tag <= next_core_resp_miss_tag;
			l2_req_ready <= next_l2_req_ready;
			l2_resp_valid <= next_l2_resp_valid;
			l2_resp_PA29 <= next_l2_resp_PA29;
			l2_resp_data256 <= next_l2_resp_data256;
			l2_snoop_inv_valid <= next_l2_snoop_inv_valid;
			l2_snoop_inv_PA29 <= next_l2_snoop_inv_PA29;
			// outbound
			last_core_resp_valid_by_way <= core_resp_valid_by_way;
			last_core_resp_tag_by_way <= core_resp_tag_by_way;
			last_core_resp_instr_16B_by_way <= core_resp_instr_16B_by_way;
			last_l2_req_valid <= l2_req_valid;
			last_l2_req_PA29 <= l2_req_PA29;
		end
	end

endmodule
